/* verilog/sldu_cfg.svh */
// Size macros for the slide unit datapath, vector register and queues

`ifndef SLDU_CFG_SVH
`define SLDU_CFG_SVH

// Bytes in one datapath word
`define SLDU_WORD_BYTES 8

// Datapath words in one vector register
`define SLDU_VREG_WORDS 4

// Instructions held in the decode queue
`define SLDU_INSN_DEPTH 4

// Result words buffered ahead of the register file port
`define SLDU_RESQ_DEPTH 2

// Instruction id width
`define SLDU_ID_W 2

`endif

/* verilog/sldu_pkg.sv */
// Slide unit package with element width, operation, word and instruction types
`default_nettype none

`include "sldu_cfg.svh"

package sldu_pkg;

  // Bytes in one vector register
  localparam int unsigned RegBytes = `SLDU_WORD_BYTES * `SLDU_VREG_WORDS;

  // Element width, also the left shift from elements to bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic {
    SLD_UP,
    SLD_DOWN
  } sld_op_e;

  // Counts from zero up to one whole register
  typedef logic [$clog2(RegBytes+1)-1:0] byte_cnt_t;
  typedef logic [8*`SLDU_WORD_BYTES-1:0] word_t;
  typedef logic [`SLDU_WORD_BYTES-1:0]   strb_t;
  typedef logic [`SLDU_ID_W-1:0]         id_t;
  typedef logic [4:0]                    vreg_t;
  // Register index on top, word index below
  typedef logic [$bits(vreg_t)+$clog2(`SLDU_VREG_WORDS)-1:0] vaddr_t;

  // Queued instruction, offset and length already in bytes
  typedef struct packed {
    sld_op_e   op;
    vew_e      vew;
    logic      vm;
    vreg_t     vd;
    id_t       id;
    byte_cnt_t off;
    byte_cnt_t cnt;
  } sld_insn_t;

endpackage

`default_nettype wire

/* verilog/sldu_insn_if.sv */
// Head-of-queue instruction interface between decode and execute
`timescale 1ns/1ps
`default_nettype none

interface sldu_insn_if import sldu_pkg::*; ();

  // Instruction at the head of the decode queue
  sld_insn_t insn;
  logic      valid;
  // Head retired by the slide engine
  logic      pop;

  modport decode_mp (
    output insn,
    output valid,
    input  pop
  );

  modport execute_mp (
    input  insn,
    input  valid,
    output pop
  );

endinterface

`default_nettype wire

/* verilog/sldu_res_if.sv */
// Result word interface between the slide engine and the result queue
`timescale 1ns/1ps
`default_nettype none

interface sldu_res_if import sldu_pkg::*; ();

  logic   push;
  word_t  wdata;
  strb_t  be;
  vaddr_t waddr;
  id_t    id;
  // Final word of its instruction
  logic   last;
  // Result queue cannot take a word this cycle
  logic   full;

  modport execute_mp (
    output push, wdata, be, waddr, id, last,
    input  full
  );

  modport result_mp (
    input  push, wdata, be, waddr, id, last,
    output full
  );

endinterface

`default_nettype wire

/* verilog/sldu_decode.sv */
// Instruction queue that converts element strides and lengths to byte counts
`timescale 1ns/1ps
`default_nettype none

`include "sldu_cfg.svh"

module sldu_decode import sldu_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // Request side
  input  wire logic      req_valid_i,
  input  wire sld_op_e   req_op_i,
  input  wire vew_e      req_vew_i,
  input  wire logic      req_vm_i,
  input  wire vreg_t     req_vd_i,
  input  wire id_t       req_id_i,
  input  wire byte_cnt_t req_stride_i,
  input  wire byte_cnt_t req_vl_i,
  output logic           req_ready_o,
  // Head instruction towards the slide engine
  sldu_insn_if.decode_mp insn_o
);

  localparam int unsigned Depth = `SLDU_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  // Queue storage, no reset on the entries
  sld_insn_t       insn_q [Depth];
  sld_insn_t       insn_new;
  logic [PntW-1:0] accept_pnt_q;
  logic [PntW-1:0] issue_pnt_q;
  // Occupancy, one bit wider than the pointers
  logic [PntW:0]   cnt_q;
  logic            accept;

  // Ready drops only with every slot taken
  assign req_ready_o = (cnt_q != (PntW+1)'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  // Element counts become byte counts here
  always_comb begin
    insn_new.op  = req_op_i;
    insn_new.vew = req_vew_i;
    insn_new.vm  = req_vm_i;
    insn_new.vd  = req_vd_i;
    insn_new.id  = req_id_i;
    insn_new.off = req_stride_i << req_vew_i;
    insn_new.cnt = req_vl_i << req_vew_i;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_new;
    end
  end

  // Accept and issue pointers wrap at the queue depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      cnt_q        <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == PntW'(Depth - 1)) ? '0 : accept_pnt_q + 1'b1;
      end
      if (insn_o.pop) begin
        issue_pnt_q <= (issue_pnt_q == PntW'(Depth - 1)) ? '0 : issue_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (PntW+1)'(accept) - (PntW+1)'(insn_o.pop);
    end
  end

  // Head is registered, so a new entry shows up one cycle after acceptance
  assign insn_o.insn  = insn_q[issue_pnt_q];
  assign insn_o.valid = (cnt_q != '0);

  // Execute only retires an instruction that is really there
  a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_o.pop |-> insn_o.valid);

endmodule

`default_nettype wire

/* verilog/sldu_execute.sv */
// Slide engine with FSM, operand and result pointers, byte shifter and byte enables
`timescale 1ns/1ps
`default_nettype none

`include "sldu_cfg.svh"

module sldu_execute import sldu_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  sldu_insn_if.execute_mp insn_i,
  // Source register stream
  input  wire word_t      operand_i,
  input  wire logic       operand_valid_i,
  output logic            operand_ready_o,
  // Mask strobe, one per result word
  input  wire strb_t      mask_i,
  input  wire logic       mask_valid_i,
  output logic            mask_ready_o,
  sldu_res_if.execute_mp  res_o
);

  localparam int unsigned WordBytes = `SLDU_WORD_BYTES;
  localparam int unsigned PntW      = $clog2(WordBytes);
  localparam int unsigned VrfW      = $clog2(`SLDU_VREG_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SKIP,
    ST_RUN
  } state_e;

  state_e          state_q, state_d;
  // Byte positions inside the operand and the result word
  logic [PntW-1:0] in_pnt_q, in_pnt_d;
  logic [PntW-1:0] out_pnt_q, out_pnt_d;
  // Word index inside the destination register
  logic [VrfW-1:0] vrf_pnt_q, vrf_pnt_d;
  // Source words still to drop before a slide-down starts
  logic [VrfW-1:0] skip_q, skip_d;
  // Bytes still to write
  byte_cnt_t       cnt_q, cnt_d;
  word_t           stage_q, stage_d;
  strb_t           stage_be_q, stage_be_d;

  logic [PntW:0]   in_rem, out_rem;
  logic [PntW:0]   step_bytes;
  logic [PntW:0]   in_sum, out_sum;
  logic            step_ok, fin, in_wrap, out_full;
  word_t           shifted;
  word_t           merged;
  strb_t           seq_en;
  strb_t           merged_be;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Room left in the operand and in the result word
  assign in_rem  = (PntW+1)'(WordBytes) - {1'b0, in_pnt_q};
  assign out_rem = (PntW+1)'(WordBytes) - {1'b0, out_pnt_q};

  // Bytes moved this step never exceed the remaining count
  always_comb begin
    step_bytes = (in_rem < out_rem) ? in_rem : out_rem;
    if (cnt_q < byte_cnt_t'(step_bytes)) begin
      step_bytes = cnt_q[PntW:0];
    end
  end

  assign in_sum   = {1'b0, in_pnt_q} + step_bytes;
  assign out_sum  = {1'b0, out_pnt_q} + step_bytes;
  assign in_wrap  = in_sum[PntW];
  assign out_full = out_sum[PntW];
  assign fin      = (cnt_q == byte_cnt_t'(step_bytes));

  // Operand byte in_pnt lands on result byte out_pnt
  assign shifted = (operand_i >> {in_pnt_q, 3'b000}) << {out_pnt_q, 3'b000};

  // Sequential enable over the bytes written this step
  always_comb begin
    for (int b = 0; b < WordBytes; b++) begin
      seq_en[b]        = (b >= int'(out_pnt_q)) && (b < int'(out_sum));
      merged[8*b +: 8] = seq_en[b] ? shifted[8*b +: 8] : stage_q[8*b +: 8];
    end
  end

  assign merged_be = stage_be_q | seq_en;

  // A step needs an operand, room downstream and a strobe when masked
  assign step_ok = (state_q == ST_RUN) && operand_valid_i && !res_o.full &&
                   (insn_i.insn.vm || mask_valid_i);

  // Operand is used up at its end or at the final step
  assign operand_ready_o = (state_q == ST_SKIP) || (step_ok && (in_wrap || fin));
  assign mask_ready_o    = step_ok && (out_full || fin) && !insn_i.insn.vm;

  // Result word leaves once full or at the end of the instruction
  assign res_o.push  = step_ok && (out_full || fin);
  assign res_o.wdata = merged;
  assign res_o.be    = merged_be & (mask_i | {WordBytes{insn_i.insn.vm}});
  assign res_o.waddr = {insn_i.insn.vd, vrf_pnt_q};
  assign res_o.id    = insn_i.insn.id;
  assign res_o.last  = fin;

  assign insn_i.pop = step_ok && fin;

  //////////////////////////////
  // Slide FSM
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    in_pnt_d   = in_pnt_q;
    out_pnt_d  = out_pnt_q;
    vrf_pnt_d  = vrf_pnt_q;
    skip_d     = skip_q;
    cnt_d      = cnt_q;
    stage_d    = stage_q;
    stage_be_d = stage_be_q;

    unique case (state_q)
      ST_IDLE: begin
        if (insn_i.valid) begin
          stage_d    = '0;
          stage_be_d = '0;
          if (insn_i.insn.op == SLD_UP) begin
            // Reading starts at source byte 0 and writing at the offset
            in_pnt_d  = '0;
            out_pnt_d = insn_i.insn.off[PntW-1:0];
            vrf_pnt_d = insn_i.insn.off[PntW +: VrfW];
            cnt_d     = insn_i.insn.cnt - insn_i.insn.off;
            state_d   = ST_RUN;
          end else begin
            // Reading starts at the offset and writing at word 0
            in_pnt_d  = insn_i.insn.off[PntW-1:0];
            out_pnt_d = '0;
            vrf_pnt_d = '0;
            skip_d    = insn_i.insn.off[PntW +: VrfW];
            cnt_d     = insn_i.insn.cnt;
            state_d   = (skip_d != '0) ? ST_SKIP : ST_RUN;
          end
        end
      end
      ST_SKIP: begin
        // Source words wholly below the offset are dropped
        if (operand_valid_i) begin
          skip_d = skip_q - 1'b1;
          if (skip_q == VrfW'(1)) begin
            state_d = ST_RUN;
          end
        end
      end
      ST_RUN: begin
        if (step_ok) begin
          stage_d    = merged;
          stage_be_d = merged_be;
          in_pnt_d   = in_sum[PntW-1:0];
          out_pnt_d  = out_sum[PntW-1:0];
          cnt_d      = cnt_q - byte_cnt_t'(step_bytes);
          if (out_full || fin) begin
            stage_d    = '0;
            stage_be_d = '0;
            vrf_pnt_d  = vrf_pnt_q + 1'b1;
          end
          if (fin) begin
            state_d = ST_IDLE;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    stage_q <= stage_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      in_pnt_q   <= '0;
      out_pnt_q  <= '0;
      vrf_pnt_q  <= '0;
      skip_q     <= '0;
      cnt_q      <= '0;
      stage_be_q <= '0;
    end else begin
      state_q    <= state_d;
      in_pnt_q   <= in_pnt_d;
      out_pnt_q  <= out_pnt_d;
      vrf_pnt_q  <= vrf_pnt_d;
      skip_q     <= skip_d;
      cnt_q      <= cnt_d;
      stage_be_q <= stage_be_d;
    end
  end

  // Decode hands over only legal slides
  a_off_below_cnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_i.valid |-> (insn_i.insn.off < insn_i.insn.cnt));

endmodule

`default_nettype wire

/* verilog/sldu_result.sv */
// Result queue with register-file request, grant handling and done pulse
`timescale 1ns/1ps
`default_nettype none

`include "sldu_cfg.svh"

module sldu_result import sldu_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  sldu_res_if.result_mp res_i,
  // Register file write port
  output logic          result_req_o,
  output vaddr_t        result_addr_o,
  output word_t         result_wdata_o,
  output strb_t         result_be_o,
  input  wire logic     result_gnt_i,
  // Instruction completion
  output logic          done_o,
  output id_t           done_id_o
);

  localparam int unsigned Depth = `SLDU_RESQ_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  typedef struct packed {
    id_t    id;
    logic   last;
    vaddr_t addr;
    word_t  wdata;
    strb_t  be;
  } entry_t;

  entry_t          mem_q [Depth];
  entry_t          head;
  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q;
  logic            retire;

  assign res_i.full = (cnt_q == (PntW+1)'(Depth));

  always_ff @(posedge clk_i) begin
    if (res_i.push) begin
      mem_q[wr_pnt_q] <= '{id: res_i.id, last: res_i.last, addr: res_i.waddr,
                           wdata: res_i.wdata, be: res_i.be};
    end
  end

  // Head is held on the port until granted
  assign head           = mem_q[rd_pnt_q];
  assign result_req_o   = (cnt_q != '0);
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;
  assign retire         = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q  <= '0;
      rd_pnt_q  <= '0;
      cnt_q     <= '0;
      done_o    <= 1'b0;
      done_id_o <= '0;
    end else begin
      if (res_i.push) begin
        wr_pnt_q <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (retire) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (PntW+1)'(res_i.push) - (PntW+1)'(retire);
      // Done follows the grant of the final word by one cycle
      done_o <= retire && head.last;
      if (retire && head.last) begin
        done_id_o <= head.id;
      end
    end
  end

  // The slide engine never writes into a full queue
  a_push_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_i.push |-> !res_i.full);

  // A waiting request keeps its payload
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && !result_gnt_i) |=> (result_req_o && $stable(result_addr_o) &&
      $stable(result_wdata_o) && $stable(result_be_o)));

endmodule

`default_nettype wire

/* verilog/sldu_top.sv */
// Slide unit top level joining decode, execute and result stages
`timescale 1ns/1ps
`default_nettype none

module sldu_top import sldu_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // Instruction requests
  input  wire logic      req_valid_i,
  input  wire sld_op_e   req_op_i,
  input  wire vew_e      req_vew_i,
  input  wire logic      req_vm_i,
  input  wire vreg_t     req_vd_i,
  input  wire id_t       req_id_i,
  input  wire byte_cnt_t req_stride_i,
  input  wire byte_cnt_t req_vl_i,
  output logic           req_ready_o,
  // Source operand stream
  input  wire word_t     operand_i,
  input  wire logic      operand_valid_i,
  output logic           operand_ready_o,
  // Mask strobes
  input  wire strb_t     mask_i,
  input  wire logic      mask_valid_i,
  output logic           mask_ready_o,
  // Register file write port
  output logic           result_req_o,
  output vaddr_t         result_addr_o,
  output word_t          result_wdata_o,
  output strb_t          result_be_o,
  input  wire logic      result_gnt_i,
  // Completion
  output logic           done_o,
  output id_t            done_id_o
);

  sldu_insn_if insn_bus ();
  sldu_res_if  res_bus ();

  sldu_decode u_decode (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vew_i, .req_vm_i,
    .req_vd_i, .req_id_i, .req_stride_i, .req_vl_i,
    .req_ready_o,
    .insn_o (insn_bus.decode_mp)
  );

  sldu_execute u_execute (
    .clk_i, .rst_ni,
    .insn_i (insn_bus.execute_mp),
    .operand_i, .operand_valid_i, .operand_ready_o,
    .mask_i, .mask_valid_i, .mask_ready_o,
    .res_o  (res_bus.execute_mp)
  );

  sldu_result u_result (
    .clk_i, .rst_ni,
    .res_i  (res_bus.result_mp),
    .result_req_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i,
    .done_o, .done_id_o
  );

endmodule

`default_nettype wire

/* verif/sldu_tb.sv */
// Directed testbench with slide reference model, stream responders, checks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "sldu_cfg.svh"

module sldu_tb import sldu_pkg::*; ();

  localparam int WordBytes = `SLDU_WORD_BYTES;
  localparam int SrcWords  = 8;
  // Eleven slides of well under 100 cycles each, stalls included
  localparam int MaxCycles = 4000;
  // Register file grant behaviour
  localparam int GntAlways = 0;
  localparam int GntRandom = 1;
  localparam int GntHold   = 2;

  // One expected register file write
  typedef struct packed {
    vaddr_t addr;
    word_t  data;
    strb_t  be;
    logic   last;
  } wr_t;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  sld_op_e   req_op_i;
  vew_e      req_vew_i;
  logic      req_vm_i;
  vreg_t     req_vd_i;
  id_t       req_id_i;
  byte_cnt_t req_stride_i;
  byte_cnt_t req_vl_i;
  logic      req_ready_o;
  word_t     operand_i;
  logic      operand_valid_i;
  logic      operand_ready_o;
  strb_t     mask_i;
  logic      mask_valid_i;
  logic      mask_ready_o;
  logic      result_req_o;
  vaddr_t    result_addr_o;
  word_t     result_wdata_o;
  strb_t     result_be_o;
  logic      result_gnt_i;
  logic      done_o;
  id_t       done_id_o;

  // Source register contents and the streams still to serve
  word_t src_mem [SrcWords];
  word_t op_q [$];
  strb_t mask_q [$];
  // Writes and done ids expected, in request order
  wr_t   exp_q [$];
  id_t   done_q [$];
  int    cycle_cnt;
  int    last_grant_cycle;
  int    gnt_mode;
  logic  req_waiting;
  wr_t   held_wr;

  sldu_top dut0 (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vew_i, .req_vm_i,
    .req_vd_i, .req_id_i, .req_stride_i, .req_vl_i,
    .req_ready_o,
    .operand_i, .operand_valid_i, .operand_ready_o,
    .mask_i, .mask_valid_i, .mask_ready_o,
    .result_req_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i,
    .done_o, .done_id_o
  );

  initial begin
    clk_i = 1'b0;
  end

  always #5 clk_i = ~clk_i;

  // Cycle counter and run limit
  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt >= MaxCycles) begin
        $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
        $display("Result: FAILED");
        $fatal(1);
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Granted write against the head of the expected list
  task automatic check_write();
    wr_t   exp_wr;
    word_t lane_mask;
    int    b;
    if (exp_q.size() == 0) begin
      stop_with_error("Register file write arrived with no write expected");
    end else begin
      exp_wr = exp_q.pop_front();
      for (b = 0; b < WordBytes; b++) begin
        lane_mask[8*b +: 8] = {8{exp_wr.be[b]}};
      end
      check_equal(64'(result_addr_o), 64'(exp_wr.addr), "write address");
      check_equal(64'(result_be_o), 64'(exp_wr.be), "write byte enables");
      // Only enabled lanes carry defined data
      check_equal(result_wdata_o & lane_mask, exp_wr.data & lane_mask, "write data");
      if (exp_wr.last) begin
        last_grant_cycle = cycle_cnt;
      end
    end
  endtask

  //////////////////////////////
  // Responders
  //////////////////////////////

  // Handshakes sampled at the falling edge, drive 1 ns after the rising edge
  initial begin : operand_feed
    logic taken;
    operand_valid_i = 1'b0;
    operand_i       = '0;
    forever begin
      @(negedge clk_i);
      taken = operand_valid_i && operand_ready_o;
      @(posedge clk_i);
      #1;
      if (taken) begin
        void'(op_q.pop_front());
      end
      operand_valid_i = (op_q.size() != 0);
      operand_i       = (op_q.size() != 0) ? op_q[0] : '0;
    end
  end

  initial begin : mask_feed
    logic taken;
    mask_valid_i = 1'b0;
    mask_i       = '0;
    forever begin
      @(negedge clk_i);
      taken = mask_valid_i && mask_ready_o;
      @(posedge clk_i);
      #1;
      if (taken) begin
        void'(mask_q.pop_front());
      end
      mask_valid_i = (mask_q.size() != 0);
      mask_i       = (mask_q.size() != 0) ? mask_q[0] : '0;
    end
  end

  // Register file port, with the waiting payload held for comparison
  initial begin : regfile_port
    result_gnt_i     = 1'b0;
    req_waiting      = 1'b0;
    held_wr          = '0;
    last_grant_cycle = -10;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (req_waiting) begin
          check_equal(64'(result_req_o), 64'd1, "request dropped before grant");
          check_equal(64'(result_addr_o), 64'(held_wr.addr), "stalled address");
          check_equal(result_wdata_o, held_wr.data, "stalled data");
          check_equal(64'(result_be_o), 64'(held_wr.be), "stalled byte enables");
        end
        req_waiting  = result_req_o && !result_gnt_i;
        held_wr.addr = result_addr_o;
        held_wr.data = result_wdata_o;
        held_wr.be   = result_be_o;
        if (result_req_o && result_gnt_i) begin
          check_write();
        end
      end
      @(posedge clk_i);
      #1;
      if (gnt_mode == GntRandom) begin
        result_gnt_i = (($urandom % 3) == 0);
      end else begin
        result_gnt_i = (gnt_mode == GntAlways);
      end
    end
  end

  // Done pulse follows the last grant by one cycle
  initial begin : done_watch
    id_t exp_id;
    forever begin
      @(negedge clk_i);
      if (rst_ni && done_o) begin
        if (done_q.size() == 0) begin
          stop_with_error("done_o pulsed with no instruction outstanding");
        end else begin
          exp_id = done_q.pop_front();
          check_equal(64'(done_id_o), 64'(exp_id), "done id");
          check_equal(64'(cycle_cnt), 64'(last_grant_cycle + 1), "done timing");
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus and reference model
  //////////////////////////////

  task automatic fill_source();
    int w;
    for (w = 0; w < SrcWords; w++) begin
      src_mem[w] = {$urandom, $urandom};
    end
  endtask

  // Builds the expected streams by the slide rule, then hands the request over
  task automatic issue_slide(input sld_op_e op, input vew_e vew, input logic vm,
                             input int vd, input int id, input int stride, input int vl);
    int    esz, off, n, nsrc, first_w, last_w, w, b, k, src_b;
    wr_t   wr;
    strb_t strb;
    logic  accepted;
    esz = 1 << int'(vew);
    off = stride * esz;
    n   = vl * esz;
    // Source words needed up to the last destination byte
    if (op == SLD_UP) begin
      nsrc = (n - off + WordBytes - 1) / WordBytes;
    end else begin
      nsrc = (off + n + WordBytes - 1) / WordBytes;
    end
    for (w = 0; w < nsrc; w++) begin
      op_q.push_back(src_mem[w]);
    end
    // Slide-up leaves words wholly below the offset untouched
    first_w = (op == SLD_UP) ? off / WordBytes : 0;
    last_w  = (n - 1) / WordBytes;
    for (w = first_w; w <= last_w; w++) begin
      wr.addr = vaddr_t'(vd * `SLDU_VREG_WORDS + w);
      wr.data = '0;
      wr.be   = '0;
      wr.last = (w == last_w);
      for (b = 0; b < WordBytes; b++) begin
        k     = w * WordBytes + b;
        src_b = (op == SLD_UP) ? k - off : k + off;
        if (k < n && src_b >= 0) begin
          wr.be[b]          = 1'b1;
          wr.data[8*b +: 8] = src_mem[src_b / WordBytes][8*(src_b % WordBytes) +: 8];
        end
      end
      if (!vm) begin
        strb = strb_t'($urandom);
        mask_q.push_back(strb);
        wr.be = wr.be & strb;
      end
      exp_q.push_back(wr);
    end
    done_q.push_back(id_t'(id));
    req_op_i     = op;
    req_vew_i    = vew;
    req_vm_i     = vm;
    req_vd_i     = vreg_t'(vd);
    req_id_i     = id_t'(id);
    req_stride_i = byte_cnt_t'(stride);
    req_vl_i     = byte_cnt_t'(vl);
    req_valid_i  = 1'b1;
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  // Every outstanding instruction done and every stream drained
  task automatic wait_done();
    while (done_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
    check_equal(64'(op_q.size()), 64'd0, "operand words not consumed");
    check_equal(64'(mask_q.size()), 64'd0, "mask strobes not consumed");
    check_equal(64'(exp_q.size()), 64'd0, "writes missing");
  endtask

  task automatic check_idle_outputs();
    @(negedge clk_i);
    check_equal(64'(req_ready_o), 64'd1, "req_ready_o when idle");
    check_equal(64'(operand_ready_o), 64'd0, "operand_ready_o when idle");
    check_equal(64'(mask_ready_o), 64'd0, "mask_ready_o when idle");
    check_equal(64'(result_req_o), 64'd0, "result_req_o when idle");
    check_equal(64'(done_o), 64'd0, "done_o when idle");
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic slide_up_bytes();
    fill_source();
    issue_slide(SLD_UP, EW8, 1'b1, 2, 1, 3, 20);
    wait_done();
  endtask

  // Offset 12 skips source word 0, vl 7 leaves trailing lanes off
  task automatic slide_down_words();
    fill_source();
    issue_slide(SLD_DOWN, EW32, 1'b1, 5, 2, 3, 6);
    wait_done();
    issue_slide(SLD_DOWN, EW32, 1'b1, 6, 3, 3, 7);
    wait_done();
  endtask

  task automatic masked_halfwords();
    fill_source();
    issue_slide(SLD_UP, EW16, 1'b0, 7, 0, 2, 14);
    issue_slide(SLD_DOWN, EW16, 1'b0, 8, 1, 5, 12);
    wait_done();
  endtask

  task automatic stalled_grants();
    fill_source();
    gnt_mode = GntRandom;
    issue_slide(SLD_UP, EW64, 1'b1, 9, 2, 1, 4);
    issue_slide(SLD_DOWN, EW8, 1'b0, 10, 3, 5, 27);
    wait_done();
    gnt_mode = GntAlways;
  endtask

  // First slide has four result words, so a held grant keeps it at the head
  task automatic full_queue();
    fill_source();
    gnt_mode = GntHold;
    issue_slide(SLD_UP, EW8, 1'b1, 11, 0, 1, 32);
    issue_slide(SLD_DOWN, EW16, 1'b1, 12, 1, 4, 10);
    issue_slide(SLD_UP, EW32, 1'b0, 13, 2, 1, 5);
    issue_slide(SLD_DOWN, EW64, 1'b1, 14, 3, 1, 3);
    @(negedge clk_i);
    check_equal(64'(req_ready_o), 64'd0, "req_ready_o with a full queue");
    @(posedge clk_i);
    #1;
    gnt_mode = GntAlways;
    wait_done();
    check_idle_outputs();
  endtask

  initial begin : main
    void'($urandom(32'hfb3d_3a2a));
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = SLD_UP;
    req_vew_i    = EW8;
    req_vm_i     = 1'b1;
    req_vd_i     = '0;
    req_id_i     = '0;
    req_stride_i = '0;
    req_vl_i     = '0;
    gnt_mode     = GntAlways;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_idle_outputs();
    slide_up_bytes();
    slide_down_words();
    masked_halfwords();
    stalled_grants();
    full_queue();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/sldu_pkg.sv
verilog/sldu_insn_if.sv
verilog/sldu_res_if.sv
verilog/sldu_decode.sv
verilog/sldu_execute.sv
verilog/sldu_result.sv
verilog/sldu_top.sv
verif/sldu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the slide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module sldu_tb \
  -o Vsldu_tb

output=$(./obj_dir/Vsldu_tb 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
